// ==== build.f ====
+incdir+include
source/beam_pkg.sv
source/beam_cmul_stage.sv
source/beam_combine_stage.sv
source/beam_channel_sum.sv
source/beam_former.sv
verif/beam_former_tb.sv

// ==== include/beam_tb_model.svh ====
/*
 * beamformer reference model
 * predicts the combined output beat from the channel beats and weights
 */
`ifndef BEAM_TB_MODEL_SVH
`define BEAM_TB_MODEL_SVH

// one sample times one complex weight, scaled back and wrapped to sample width
function automatic beam_pkg::complex_sample_t model_weight_sample(
    input beam_pkg::complex_sample_t sample,
    input beam_pkg::weight_t         weight
);
    logic signed [beam_pkg::product_width:0] re_full;
    logic signed [beam_pkg::product_width:0] im_full;
    beam_pkg::complex_sample_t               result;

    re_full = (sample.re * weight.re) - (sample.im * weight.im);
    im_full = (sample.re * weight.im) + (sample.im * weight.re);
    re_full = re_full >>> beam_pkg::weight_frac;
    im_full = im_full >>> beam_pkg::weight_frac;
    result.re = re_full[beam_pkg::sample_width-1:0];
    result.im = im_full[beam_pkg::sample_width-1:0];
    return result;
endfunction

// expected output beat, beats and weights hold one entry per channel
function automatic beam_pkg::beat_t model_beat(
    input beam_pkg::beat_t   beats [],
    input beam_pkg::weight_t weights []
);
    beam_pkg::complex_sample_t weighted;
    longint                    acc_re;
    longint                    acc_im;
    beam_pkg::beat_t           result;

    for (int lane = 0; lane < beam_pkg::lane_count; lane++) begin
        acc_re = 0;
        acc_im = 0;
        for (int ch = 0; ch < beats.size(); ch++) begin
            weighted = model_weight_sample(beats[ch][lane], weights[ch]);
            acc_re += weighted.re;
            acc_im += weighted.im;
        end
        // wrap the full-width channel sum to sample width
        result[lane].re = acc_re[beam_pkg::sample_width-1:0];
        result[lane].im = acc_im[beam_pkg::sample_width-1:0];
    end
    return result;
endfunction

`endif

// ==== verif/beam_former_tb.sv ====
/*
 * beamformer testbench
 * drives channel beats and weights, predicts each combined beat with the model
 * and checks the output stream three cycles later with concurrent assertions
 */
`timescale 1ns/100ps

module beam_former_tb;

    localparam int channel_count = 4;

    // stimulus lengths, one clock cycle per driven cycle
    localparam int reset_cycles  = 16;
    localparam int settle_cycles = 2;
    localparam int scale_beats   = 8;
    localparam int random_beats  = 40;
    localparam int extreme_beats = 16;
    localparam int gap_cycles    = 60;
    localparam int hold_beats    = 6;
    localparam int drain_cycles  = 4;
    // each held beat takes a valid cycle and a cycle with new weights
    localparam int stim_cycles = settle_cycles + scale_beats + random_beats
                               + extreme_beats + gap_cycles + 2 * hold_beats + drain_cycles;
    localparam int timeout_limit = reset_cycles + stim_cycles + 20;

    logic                 clock = 1'b0;
    logic                 resetn;
    beam_pkg::beat_t      in_beats [channel_count];
    beam_pkg::weight_t    weights [channel_count];
    beam_pkg::beat_ctrl_t in_ctrl;
    beam_pkg::beat_t      out_beat;
    beam_pkg::beat_ctrl_t out_ctrl;

    // values for the next driven cycle, dynamic so the model can take them directly
    beam_pkg::beat_t   next_beats [];
    beam_pkg::weight_t next_weights [];

    // expected beats in input order, popped when their output cycle comes up
    beam_pkg::beat_t exp_queue [$];

    // input control delayed to line up with the output, and the matching beat
    beam_pkg::beat_ctrl_t [2:0] ctrl_hist;
    beam_pkg::beat_t            exp_beat;

    int cycle_count = 0;

    `include "beam_tb_model.svh"

    beam_former #(
        .channel_count (channel_count)
    ) dut_i (
        .clock    (clock),
        .resetn   (resetn),
        .in_beats (in_beats),
        .weights  (weights),
        .in_ctrl  (in_ctrl),
        .out_beat (out_beat),
        .out_ctrl (out_ctrl)
    );

    always #10 clock = ~clock;

    task automatic stop_on_error();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_error(input string name, input logic [255:0] got,
                               input logic [255:0] expected);
        $display("Error: %s got %0h expected %0h", name, got, expected);
        stop_on_error();
    endtask

    // the run is bounded by the known length of the stimulus
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("the run did not finish within %0d cycles", timeout_limit);
            stop_on_error();
        end
    end

    // three-cycle delay line for control, expected beat loaded one cycle ahead
    // of the output so both are settled when the assertions sample them
    always @(posedge clock) begin
        if (!resetn) begin
            ctrl_hist <= '0;
            exp_beat  <= '0;
        end else begin
            ctrl_hist[0] <= in_ctrl;
            ctrl_hist[1] <= ctrl_hist[0];
            ctrl_hist[2] <= ctrl_hist[1];
            if (ctrl_hist[1].valid) begin
                if (exp_queue.size() == 0) begin
                    $display("an output beat was due but no expected beat was queued");
                    stop_on_error();
                end else begin
                    exp_beat <= exp_queue.pop_front();
                end
            end else begin
                exp_beat <= '0;
            end
        end
    end

    // the first edge is skipped since the registers only clear on it
    ctrl_check: assert property (@(posedge clock) cycle_count != 0 |-> out_ctrl == ctrl_hist[2])
        else value_error("out_ctrl", $sampled(out_ctrl), $sampled(ctrl_hist[2]));

    beat_check: assert property (@(posedge clock) cycle_count != 0 |-> out_beat == exp_beat)
        else value_error("out_beat", $sampled(out_beat), $sampled(exp_beat));

    // idle output data must read as zero
    idle_check: assert property (@(posedge clock)
        cycle_count != 0 && !out_ctrl.valid |-> out_beat == '0)
        else value_error("out_beat", $sampled(out_beat), '0);

    function automatic logic [beam_pkg::sample_width-1:0] random_sample();
        logic [31:0] r;
        r = $urandom;
        return r[beam_pkg::sample_width-1:0];
    endfunction

    function automatic logic [beam_pkg::weight_width-1:0] random_weight_part();
        logic [31:0] r;
        r = $urandom;
        return r[beam_pkg::weight_width-1:0];
    endfunction

    // full-scale positive or negative sample
    function automatic logic [beam_pkg::sample_width-1:0] extreme_sample();
        return ($urandom % 2 == 0) ? 16'h7fff : 16'h8000;
    endfunction

    // largest positive or negative weight component
    function automatic logic [beam_pkg::weight_width-1:0] extreme_weight_part();
        return ($urandom % 2 == 0) ? 8'sd127 : -8'sd128;
    endfunction

    task automatic fill_random_beats();
        for (int ch = 0; ch < channel_count; ch++) begin
            for (int lane = 0; lane < beam_pkg::lane_count; lane++) begin
                next_beats[ch][lane].re = random_sample();
                next_beats[ch][lane].im = random_sample();
            end
        end
    endtask

    task automatic fill_random_weights();
        for (int ch = 0; ch < channel_count; ch++) begin
            next_weights[ch].re = random_weight_part();
            next_weights[ch].im = random_weight_part();
        end
    endtask

    // drives the staged values 2 ns after the edge and queues the prediction
    task automatic apply_cycle(input logic valid, input logic last);
        @(posedge clock);
        #2;
        for (int ch = 0; ch < channel_count; ch++) begin
            in_beats[ch] = next_beats[ch];
            weights[ch]  = next_weights[ch];
        end
        in_ctrl.valid = valid;
        in_ctrl.last  = valid & last;
        if (valid) begin
            exp_queue.push_back(model_beat(next_beats, next_weights));
        end
    endtask

    // channel 0 at 127/128 alone, other channels contribute nothing
    task automatic run_scaling_test();
        for (int ch = 0; ch < channel_count; ch++) begin
            next_weights[ch] = '0;
        end
        next_weights[0].re = 8'sd127;
        for (int i = 0; i < scale_beats; i++) begin
            fill_random_beats();
            apply_cycle(1'b1, i == scale_beats - 1);
        end
    endtask

    // back to back beats keep all three stages busy
    task automatic run_random_test();
        for (int i = 0; i < random_beats; i++) begin
            fill_random_beats();
            fill_random_weights();
            apply_cycle(1'b1, $urandom % 2);
        end
    endtask

    task automatic run_extreme_test();
        for (int i = 0; i < extreme_beats; i++) begin
            for (int ch = 0; ch < channel_count; ch++) begin
                next_weights[ch].re = extreme_weight_part();
                next_weights[ch].im = extreme_weight_part();
                for (int lane = 0; lane < beam_pkg::lane_count; lane++) begin
                    next_beats[ch][lane].re = extreme_sample();
                    next_beats[ch][lane].im = extreme_sample();
                end
            end
            apply_cycle(1'b1, i == extreme_beats - 1);
        end
    endtask

    // idle cycles still carry random data, which must not reach the output
    task automatic run_gap_test();
        for (int i = 0; i < gap_cycles; i++) begin
            fill_random_beats();
            fill_random_weights();
            apply_cycle($urandom % 3 != 0, $urandom % 2);
        end
    endtask

    // the cycle after each valid beat gets new weights
    task automatic run_weight_hold_test();
        for (int i = 0; i < hold_beats; i++) begin
            fill_random_beats();
            fill_random_weights();
            apply_cycle(1'b1, 1'b0);
            for (int ch = 0; ch < channel_count; ch++) begin
                next_weights[ch] = ~next_weights[ch];
            end
            apply_cycle(1'b0, 1'b0);
        end
    endtask

    initial begin
        void'($urandom(32'h3ee06bbd));
        next_beats   = new[channel_count];
        next_weights = new[channel_count];
        resetn  = 1'b0;
        in_ctrl = '0;
        for (int ch = 0; ch < channel_count; ch++) begin
            in_beats[ch]     = '0;
            weights[ch]      = '0;
            next_beats[ch]   = '0;
            next_weights[ch] = '0;
        end

        repeat (reset_cycles) @(posedge clock);
        #2;
        resetn = 1'b1;

        // a short quiet stretch shows the output stays zero right after reset
        repeat (settle_cycles) apply_cycle(1'b0, 1'b0);

        run_scaling_test();
        run_random_test();
        run_extreme_test();
        run_gap_test();
        run_weight_hold_test();
        repeat (drain_cycles) apply_cycle(1'b0, 1'b0);

        if (exp_queue.size() != 0) begin
            $display("%0d expected beats never appeared at the output", exp_queue.size());
            stop_on_error();
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// ==== source/beam_former.sv ====
/*
 * four-channel complex beamformer top
 * weights each channel's beat and sums all channels, three cycles from input to output
 */
`timescale 1ns/100ps

module beam_former #(
    parameter int channel_count = 4
) (
    input  logic                   clock,
    input  logic                   resetn,
    // one beat of lane_count complex samples per channel
    input  beam_pkg::beat_t        in_beats [channel_count],
    // one complex weight per channel, sampled with its beat
    input  beam_pkg::weight_t      weights [channel_count],
    input  beam_pkg::beat_ctrl_t   in_ctrl,
    // the combined beat, zero whenever out_ctrl.valid is low
    output beam_pkg::beat_t        out_beat,
    output beam_pkg::beat_ctrl_t   out_ctrl
);

    // partial products, one cycle after the input
    beam_pkg::beat_products_t prod_beats [channel_count];
    beam_pkg::beat_ctrl_t     prod_ctrl;

    // weighted samples per channel, two cycles after the input
    beam_pkg::beat_t          weighted_beats [channel_count];
    beam_pkg::beat_ctrl_t     weighted_ctrl;

    // the four products of every sample and its weight
    beam_cmul_stage #(
        .channel_count (channel_count)
    ) u_cmul (
        .clock      (clock),
        .resetn     (resetn),
        .in_beats   (in_beats),
        .weights    (weights),
        .in_ctrl    (in_ctrl),
        .prod_beats (prod_beats),
        .prod_ctrl  (prod_ctrl)
    );

    // recombine into complex results and drop the weight fraction
    beam_combine_stage #(
        .channel_count (channel_count)
    ) u_combine (
        .clock          (clock),
        .resetn         (resetn),
        .prod_beats     (prod_beats),
        .prod_ctrl      (prod_ctrl),
        .weighted_beats (weighted_beats),
        .weighted_ctrl  (weighted_ctrl)
    );

    // add all channels into the single output beat
    beam_channel_sum #(
        .channel_count (channel_count)
    ) u_sum (
        .clock          (clock),
        .resetn         (resetn),
        .weighted_beats (weighted_beats),
        .weighted_ctrl  (weighted_ctrl),
        .out_beat       (out_beat),
        .out_ctrl       (out_ctrl)
    );

endmodule

// ==== source/beam_channel_sum.sv ====
/*
 * beamformer stage 3, channel sum
 * adds the weighted beats of all channels lane by lane into one output beat
 */
`timescale 1ns/100ps

module beam_channel_sum #(
    parameter int channel_count = 4
) (
    input  logic                   clock,
    input  logic                   resetn,
    input  beam_pkg::beat_t        weighted_beats [channel_count],
    input  beam_pkg::beat_ctrl_t   weighted_ctrl,
    output beam_pkg::beat_t        out_beat,
    output beam_pkg::beat_ctrl_t   out_ctrl
);

    // wide enough that the sum of all channels never overflows
    localparam int sum_width = beam_pkg::sample_width + $clog2(channel_count) + 1;

    beam_pkg::beat_t sum_next;

    always_comb begin
        logic signed [sum_width-1:0] acc_re;
        logic signed [sum_width-1:0] acc_im;

        acc_re = '0;
        acc_im = '0;
        for (int lane = 0; lane < beam_pkg::lane_count; lane++) begin
            acc_re = '0;
            acc_im = '0;
            // the real and imaginary halves are summed separately
            for (int ch = 0; ch < channel_count; ch++) begin
                acc_re = acc_re + weighted_beats[ch][lane].re;
                acc_im = acc_im + weighted_beats[ch][lane].im;
            end
            // truncate to sample width, a sum out of range wraps
            sum_next[lane].re = acc_re[beam_pkg::sample_width-1:0];
            sum_next[lane].im = acc_im[beam_pkg::sample_width-1:0];
        end
    end

    // the output beat is cleared whenever no valid beat is presented,
    // so downstream logic sees zero data on every idle cycle
    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_ctrl <= '0;
            out_beat <= '0;
        end else begin
            out_ctrl <= weighted_ctrl;
            if (weighted_ctrl.valid) begin
                out_beat <= sum_next;
            end else begin
                out_beat <= '0;
            end
        end
    end

endmodule

// ==== source/beam_combine_stage.sv ====
/*
 * beamformer stage 2, complex recombination
 * forms rr-ii and ir+ri per lane and realigns the result to sample width
 */
`timescale 1ns/100ps

module beam_combine_stage #(
    parameter int channel_count = 4
) (
    input  logic                       clock,
    input  logic                       resetn,
    input  beam_pkg::beat_products_t   prod_beats [channel_count],
    input  beam_pkg::beat_ctrl_t       prod_ctrl,
    output beam_pkg::beat_t            weighted_beats [channel_count],
    output beam_pkg::beat_ctrl_t       weighted_ctrl
);

    // one guard bit above the product so the sum or difference cannot overflow
    localparam int result_width = beam_pkg::product_width + 1;

    // weighted samples before the pipeline register
    beam_pkg::beat_t weighted_next [channel_count];

    always_comb begin
        logic signed [result_width-1:0] re_full;
        logic signed [result_width-1:0] im_full;
        logic signed [result_width-1:0] re_scaled;
        logic signed [result_width-1:0] im_scaled;

        re_full   = '0;
        im_full   = '0;
        re_scaled = '0;
        im_scaled = '0;
        for (int ch = 0; ch < channel_count; ch++) begin
            for (int lane = 0; lane < beam_pkg::lane_count; lane++) begin
                // (a + jb)(c + jd) gives ac - bd for the real part
                re_full = prod_beats[ch][lane].rr - prod_beats[ch][lane].ii;
                // and ad + bc for the imaginary part
                im_full = prod_beats[ch][lane].ir + prod_beats[ch][lane].ri;

                // drop the weight fraction bits, keeping the sign
                re_scaled = re_full >>> beam_pkg::weight_frac;
                im_scaled = im_full >>> beam_pkg::weight_frac;

                // only the low sample bits are kept, so a result that does not
                // fit wraps around instead of saturating
                weighted_next[ch][lane].re = re_scaled[beam_pkg::sample_width-1:0];
                weighted_next[ch][lane].im = im_scaled[beam_pkg::sample_width-1:0];
            end
        end
    end

    // the data register follows its beat and holds between beats
    always_ff @(posedge clock) begin
        if (prod_ctrl.valid) begin
            for (int ch = 0; ch < channel_count; ch++) begin
                weighted_beats[ch] <= weighted_next[ch];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            weighted_ctrl <= '0;
        end else begin
            weighted_ctrl <= prod_ctrl;
        end
    end

endmodule

// ==== source/beam_cmul_stage.sv ====
/*
 * beamformer stage 1, complex multiply
 * registers the four signed partial products of every sample and its channel weight
 */
`timescale 1ns/100ps

module beam_cmul_stage #(
    parameter int channel_count = 4
) (
    input  logic                       clock,
    input  logic                       resetn,
    // one beat per channel, all channels share the valid strobe
    input  beam_pkg::beat_t            in_beats [channel_count],
    // weights are levels, only the value present on a valid beat matters
    input  beam_pkg::weight_t          weights [channel_count],
    input  beam_pkg::beat_ctrl_t       in_ctrl,
    output beam_pkg::beat_products_t   prod_beats [channel_count],
    output beam_pkg::beat_ctrl_t       prod_ctrl
);

    // products of the current input, before the pipeline register
    beam_pkg::beat_products_t prod_next [channel_count];

    // every sample of a channel is scaled by that channel's one weight
    // the sample and weight fields are signed, so each product is a signed
    // multiply that is sign-extended into the full product width
    always_comb begin
        for (int ch = 0; ch < channel_count; ch++) begin
            for (int lane = 0; lane < beam_pkg::lane_count; lane++) begin
                // real sample times real weight
                prod_next[ch][lane].rr = in_beats[ch][lane].re * weights[ch].re;
                // imaginary sample times imaginary weight, subtracted later
                prod_next[ch][lane].ii = in_beats[ch][lane].im * weights[ch].im;
                // the two cross terms that form the imaginary result
                prod_next[ch][lane].ri = in_beats[ch][lane].im * weights[ch].re;
                prod_next[ch][lane].ir = in_beats[ch][lane].re * weights[ch].im;
            end
        end
    end

    // the products load only on a valid beat and hold otherwise
    // since the weight is folded into the product here, a weight change after
    // the beat cannot reach that beat's result
    always_ff @(posedge clock) begin
        if (in_ctrl.valid) begin
            for (int ch = 0; ch < channel_count; ch++) begin
                prod_beats[ch] <= prod_next[ch];
            end
        end
    end

    // control bits move one stage with the data
    always_ff @(posedge clock) begin
        if (!resetn) begin
            prod_ctrl <= '0;
        end else begin
            prod_ctrl <= in_ctrl;
        end
    end

endmodule

// ==== source/beam_pkg.sv ====
/*
 * beamformer shared definitions
 * fixed-point widths, complex sample and weight types, and the control bits
 * that travel with each beat through the pipeline
 */
package beam_pkg;

    // one real or imaginary sample, signed two's complement
    localparam int sample_width = 16;

    // one weight component, signed, read as a fraction below one
    localparam int weight_width = 8;

    // fraction bits of a weight, so 127 stands for 127/128
    localparam int weight_frac = 7;

    // complex samples carried in one beat of one channel
    localparam int lane_count = 8;

    // a full signed product of a sample and a weight component needs no rounding
    localparam int product_width = sample_width + weight_width;

    // the real part sits in the upper half of the 32-bit word
    typedef struct packed {
        logic signed [sample_width-1:0] re;
        logic signed [sample_width-1:0] im;
    } complex_sample_t;

    // lane 0 is in the low bits, which keeps the layout of the old tdata words
    typedef complex_sample_t [lane_count-1:0] beat_t;

    // per-channel complex weight
    typedef struct packed {
        logic signed [weight_width-1:0] re;
        logic signed [weight_width-1:0] im;
    } weight_t;

    // the four partial products of one lane
    // rr and ii build the real part, ri and ir build the imaginary part
    typedef struct packed {
        logic signed [product_width-1:0] rr;
        logic signed [product_width-1:0] ii;
        logic signed [product_width-1:0] ri;
        logic signed [product_width-1:0] ir;
    } lane_products_t;

    typedef lane_products_t [lane_count-1:0] beat_products_t;

    // last is only meaningful while valid is high
    typedef struct packed {
        logic valid;
        logic last;
    } beat_ctrl_t;

endpackage
